// ==== include/sdram_macros.svh ====
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// geometry: 2 banks x 2048 rows x 256 cols, 16 bit words
`define SDRAM_ADDR_W          20  // {bank, row, col}
`define SDRAM_ROW_W           11  // also the pin address width
`define SDRAM_COL_W           8
`define SDRAM_DATA_W          16
`define SDRAM_BURST_W         9   // holds 1..256

// timing in clock cycles
`define SDRAM_TRP             4   // precharge period
`define SDRAM_TRC             6   // auto refresh period
`define SDRAM_TMRD            6   // load mode to next command
`define SDRAM_TRCD            2   // active to read/write
`define SDRAM_CL              3   // cas latency
`define SDRAM_TWR             2   // write recovery

// init sequence
`define SDRAM_INIT_REFRESHES  8
`define SDRAM_POWERUP_CYCLES  20000  // 200us at 100MHz

// mode register fields
`define SDRAM_MODE_CL         3
`define SDRAM_MODE_BURST_PAGE 7   // full page burst

`endif

// ==== design/sdram_pkg.sv ====
`include "sdram_macros.svh"

package sdram_pkg;

  // pin level commands, decoded in the command encoder
  typedef enum logic [3:0] {
    cmd_inhibit, cmd_nop, cmd_active, cmd_read, cmd_write,
    cmd_burst_stop, cmd_precharge, cmd_auto_refresh, cmd_load_mode
  } sdram_cmd_e;

  typedef enum logic [2:0] {
    ini_wait_power, ini_precharge, ini_wait_trp, ini_refresh,
    ini_wait_trc, ini_load_mode, ini_wait_tmrd, ini_done
  } init_state_e;

  typedef enum logic [3:0] {
    acc_idle, acc_active, acc_wait_trcd, acc_read, acc_wait_cl, acc_read_data,
    acc_write, acc_write_data, acc_wait_twr, acc_precharge, acc_wait_trp
  } access_state_e;

  typedef enum logic {op_read, op_write} access_op_e;

  typedef struct packed {
    sdram_cmd_e                cmd;
    logic                      ba;
    logic [`SDRAM_ROW_W-1:0]   addr;
  } sdram_req_t;

  typedef logic [`SDRAM_ADDR_W-1:0]  sys_addr_t;
  typedef logic [`SDRAM_BURST_W-1:0] burst_t;
  typedef logic [`SDRAM_DATA_W-1:0]  sdram_data_t;

endpackage

// ==== design/sdram_init_seq.sv ====
`include "sdram_macros.svh"

module sdram_init_seq #(
  parameter int init_wait_cycles = `SDRAM_POWERUP_CYCLES
) (
  input  logic                   clk,
  input  logic                   rst_n,
  output sdram_pkg::sdram_req_t  init_req,
  output logic                   init_done
);
  import sdram_pkg::*;

  localparam int cnt_w = $clog2(init_wait_cycles + 16);  // room for the short waits too
  localparam int ref_w = $clog2(`SDRAM_INIT_REFRESHES + 1);

  localparam logic [cnt_w-1:0] pwr_last  = cnt_w'(init_wait_cycles - 1);
  localparam logic [cnt_w-1:0] trp_last  = cnt_w'(`SDRAM_TRP - 1);
  localparam logic [cnt_w-1:0] trc_last  = cnt_w'(`SDRAM_TRC - 1);
  localparam logic [cnt_w-1:0] tmrd_last = cnt_w'(`SDRAM_TMRD - 1);
  localparam logic [ref_w-1:0] ref_total = ref_w'(`SDRAM_INIT_REFRESHES);

  // A10 reserved, A9 burst write, op mode 00, then cl, sequential, burst length
  localparam logic [`SDRAM_ROW_W-1:0] mode_word = {
    1'b0, 1'b0, 2'b00, 3'(`SDRAM_MODE_CL), 1'b0, 3'(`SDRAM_MODE_BURST_PAGE)
  };

  init_state_e      state, state_next;
  logic [cnt_w-1:0] dly_cnt;   // cycles spent in the current state
  logic [ref_w-1:0] ref_cnt;   // refreshes issued so far

  always_comb begin
    state_next = state;
    case (state)
      ini_wait_power: if (dly_cnt == pwr_last) state_next = ini_precharge;
      ini_precharge:  state_next = ini_wait_trp;
      ini_wait_trp:   if (dly_cnt == trp_last) state_next = ini_refresh;
      ini_refresh:    state_next = ini_wait_trc;
      ini_wait_trc: begin
        if (dly_cnt == trc_last)
          state_next = (ref_cnt == ref_total) ? ini_load_mode : ini_refresh;
      end
      ini_load_mode:  state_next = ini_wait_tmrd;
      ini_wait_tmrd:  if (dly_cnt == tmrd_last) state_next = ini_done;
      default:        state_next = ini_done;   // done holds
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ini_wait_power;
      dly_cnt <= '0;
      ref_cnt <= '0;
    end else begin
      state <= state_next;
      if (state_next != state)
        dly_cnt <= '0;               // every wait starts from zero
      else if (state != ini_done)
        dly_cnt <= dly_cnt + 1'b1;   // frozen once done
      if (state == ini_refresh)
        ref_cnt <= ref_cnt + 1'b1;
    end
  end

  // command request, nop outside the three command states
  always_comb begin
    init_req.cmd  = cmd_nop;
    init_req.ba   = 1'b1;
    init_req.addr = '1;             // A10 high, all banks for precharge
    case (state)
      ini_precharge: init_req.cmd = cmd_precharge;
      ini_refresh:   init_req.cmd = cmd_auto_refresh;
      ini_load_mode: begin
        init_req.cmd  = cmd_load_mode;
        init_req.ba   = 1'b0;
        init_req.addr = mode_word;
      end
      default:       init_req.cmd = cmd_nop;
    endcase
  end

  assign init_done = (state == ini_done);

endmodule

// ==== design/sdram_access_fsm.sv ====
`include "sdram_macros.svh"

module sdram_access_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   init_done,
  input  logic                   wr_req,
  input  sdram_pkg::sys_addr_t   wr_addr,
  input  sdram_pkg::burst_t      wr_burst,
  input  logic                   rd_req,
  input  sdram_pkg::sys_addr_t   rd_addr,
  input  sdram_pkg::burst_t      rd_burst,
  output logic                   wr_ack,
  output sdram_pkg::sdram_req_t  access_req,
  output logic                   wr_phase,
  output logic                   rd_window
);
  import sdram_pkg::*;

  localparam int cnt_w = `SDRAM_BURST_W;   // cl + 256 still fits

  // active is one cycle, so trcd-1 wait cycles give the full trcd gap
  localparam logic [cnt_w-1:0] trcd_last = cnt_w'(`SDRAM_TRCD - 2);
  localparam logic [cnt_w-1:0] cl_cnt    = cnt_w'(`SDRAM_CL);
  localparam logic [cnt_w-1:0] twr_last  = cnt_w'(`SDRAM_TWR - 1);
  localparam logic [cnt_w-1:0] trp_last  = cnt_w'(`SDRAM_TRP - 1);

  access_state_e    state, state_next;
  access_op_e       op_q;
  sys_addr_t        addr_q;     // latched at accept
  burst_t           burst_q;
  logic [cnt_w-1:0] cnt;
  logic             cnt_clr;
  logic             bank;
  logic [`SDRAM_ROW_W-1:0] row;
  logic [`SDRAM_COL_W-1:0] col;
  logic             read_stop;  // burst stop inside the read path
  logic             write_stop; // burst stop after the last write word

  assign bank = addr_q[`SDRAM_ADDR_W-1];
  assign row  = addr_q[`SDRAM_ADDR_W-2 -: `SDRAM_ROW_W];
  assign col  = addr_q[`SDRAM_COL_W-1:0];

  always_comb begin
    state_next = state;
    case (state)
      acc_idle:       if (init_done && (wr_req || rd_req)) state_next = acc_active;
      acc_active:     state_next = acc_wait_trcd;
      acc_wait_trcd: begin
        if (cnt == trcd_last)
          state_next = (op_q == op_write) ? acc_write : acc_read;
      end
      acc_read:       state_next = acc_wait_cl;
      acc_wait_cl:    if (cnt == cl_cnt) state_next = acc_read_data;
      acc_read_data:  if (cnt == burst_q + cl_cnt) state_next = acc_precharge;
      acc_write:      state_next = (burst_q == burst_t'(1)) ? acc_wait_twr : acc_write_data;
      acc_write_data: if (cnt == burst_q - burst_t'(2)) state_next = acc_wait_twr;
      acc_wait_twr:   if (cnt == twr_last) state_next = acc_precharge;
      acc_precharge:  state_next = acc_wait_trp;
      acc_wait_trp:   if (cnt == trp_last) state_next = acc_idle;
      default:        state_next = acc_idle;
    endcase
  end

  // read path keeps counting from the read command, cnt = cycles since read
  assign cnt_clr = (state == acc_idle) ||
                   ((state_next != state) && (state != acc_read) && (state != acc_wait_cl));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= acc_idle;
      cnt   <= '0;
      op_q  <= op_read;
    end else begin
      state <= state_next;
      cnt   <= cnt_clr ? '0 : cnt + 1'b1;
      if (state == acc_idle)
        op_q <= wr_req ? op_write : op_read;   // write wins a tie
    end
  end

  // request fields, sampled every idle cycle and frozen after accept
  always_ff @(posedge clk) begin
    if (state == acc_idle) begin
      addr_q  <= wr_req ? wr_addr : rd_addr;
      burst_q <= wr_req ? wr_burst : rd_burst;
    end
  end

  // stop at read+burst on the request side, last data comes cl-1 later
  assign read_stop  = (state inside {acc_read, acc_wait_cl, acc_read_data}) &&
                      (cnt == burst_q);
  assign write_stop = (state == acc_wait_twr) && (cnt == '0);

  always_comb begin
    access_req.cmd  = cmd_nop;
    access_req.ba   = 1'b1;
    access_req.addr = '1;
    if (state == acc_active) begin
      access_req.cmd  = cmd_active;
      access_req.ba   = bank;
      access_req.addr = row;
    end else if (state == acc_read || state == acc_write) begin
      access_req.cmd  = (state == acc_read) ? cmd_read : cmd_write;
      access_req.ba   = bank;
      access_req.addr = {{(`SDRAM_ROW_W - `SDRAM_COL_W){1'b0}}, col};  // A10 low, no auto pre
    end else if (read_stop || write_stop) begin
      access_req.cmd  = cmd_burst_stop;
    end else if (state == acc_precharge) begin
      access_req.cmd  = cmd_precharge;   // A10 low, this bank only
      access_req.ba   = bank;
      access_req.addr = '0;
    end
  end

  assign wr_phase  = (state == acc_write) || (state == acc_write_data);
  assign wr_ack    = wr_phase;   // one ack per word taken
  assign rd_window = (state == acc_read_data);

endmodule

// ==== design/sdram_cmd_encoder.sv ====
module sdram_cmd_encoder (
  input  logic                   clk,
  input  logic                   rst_n,
  input  sdram_pkg::sdram_req_t  init_req,
  input  sdram_pkg::sdram_req_t  access_req,
  output logic                   sdram_cke,
  output logic                   sdram_cs_n,
  output logic                   sdram_ras_n,
  output logic                   sdram_cas_n,
  output logic                   sdram_we_n,
  output logic                   sdram_ba,
  output logic [10:0]            sdram_addr
);
  import sdram_pkg::*;

  sdram_req_t sel;
  logic [4:0] pins_q;   // {cke, cs_n, ras_n, cas_n, we_n}

  // command to {cke, cs_n, ras_n, cas_n, we_n}
  function automatic logic [4:0] cmd_pins(input sdram_cmd_e cmd);
    logic [4:0] p;
    case (cmd)
      cmd_inhibit:      p = 5'b01111;   // cke low, deselected
      cmd_active:       p = 5'b10011;
      cmd_read:         p = 5'b10101;
      cmd_write:        p = 5'b10100;
      cmd_burst_stop:   p = 5'b10110;
      cmd_precharge:    p = 5'b10010;
      cmd_auto_refresh: p = 5'b10001;
      cmd_load_mode:    p = 5'b10000;
      default:          p = 5'b10111;   // nop
    endcase
    return p;
  endfunction

  // the two sources never issue in the same cycle
  assign sel = (init_req.cmd != cmd_nop) ? init_req : access_req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pins_q     <= cmd_pins(cmd_inhibit);
      sdram_ba   <= 1'b1;
      sdram_addr <= '1;
    end else begin
      pins_q <= cmd_pins(sel.cmd);
      if (sel.cmd == cmd_nop) begin
        sdram_ba   <= 1'b1;   // park lines high when idle
        sdram_addr <= '1;
      end else begin
        sdram_ba   <= sel.ba;
        sdram_addr <= sel.addr;
      end
    end
  end

  assign {sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = pins_q;

endmodule

// ==== design/sdram_data_path.sv ====
module sdram_data_path (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_phase,
  input  sdram_pkg::sdram_data_t wr_data,
  input  logic                   rd_window,
  input  sdram_pkg::sdram_data_t sdram_dq_in,
  output sdram_pkg::sdram_data_t sdram_dq_out,
  output logic                   sdram_dq_oe,
  output sdram_pkg::sdram_data_t rd_data,
  output logic                   rd_ack
);

  // write side, word lands on the pins with the write command
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      sdram_dq_oe <= 1'b0;
    else
      sdram_dq_oe <= wr_phase;   // drive only while words are taken
  end

  always_ff @(posedge clk) begin
    if (wr_phase)
      sdram_dq_out <= wr_data;
  end

  // read side, one cycle behind the pins
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      rd_ack <= 1'b0;
    else
      rd_ack <= rd_window;
  end

  always_ff @(posedge clk) begin
    if (rd_window)
      rd_data <= sdram_dq_in;   // hold last word outside the window
  end

endmodule

// ==== design/sdram_ctrl_top.sv ====
`include "sdram_macros.svh"

module sdram_ctrl_top #(
  parameter int init_wait_cycles = `SDRAM_POWERUP_CYCLES
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // write port
  input  logic                     wr_req,
  output logic                     wr_ack,
  input  sdram_pkg::sys_addr_t     wr_addr,
  input  sdram_pkg::burst_t        wr_burst,
  input  sdram_pkg::sdram_data_t   wr_data,
  // read port
  input  logic                     rd_req,
  output logic                     rd_ack,
  input  sdram_pkg::sys_addr_t     rd_addr,
  input  sdram_pkg::burst_t        rd_burst,
  output sdram_pkg::sdram_data_t   rd_data,
  output logic                     init_done,
  // device pins
  output logic                     sdram_cke,
  output logic                     sdram_cs_n,
  output logic                     sdram_ras_n,
  output logic                     sdram_cas_n,
  output logic                     sdram_we_n,
  output logic                     sdram_ba,
  output logic [`SDRAM_ROW_W-1:0]  sdram_addr,
  input  sdram_pkg::sdram_data_t   sdram_dq_in,   // split dq bus
  output sdram_pkg::sdram_data_t   sdram_dq_out,
  output logic                     sdram_dq_oe
);
  import sdram_pkg::*;

  sdram_req_t init_req;    // init sequence commands
  sdram_req_t access_req;  // read/write commands
  logic       wr_phase;    // write word taken this cycle
  logic       rd_window;   // read word on the pins this cycle

  sdram_init_seq #(
    .init_wait_cycles (init_wait_cycles)
  ) sdram_init_seq_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .init_req  (init_req),
    .init_done (init_done)
  );

  sdram_access_fsm sdram_access_fsm_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .init_done  (init_done),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_burst   (wr_burst),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_burst   (rd_burst),
    .wr_ack     (wr_ack),
    .access_req (access_req),
    .wr_phase   (wr_phase),
    .rd_window  (rd_window)
  );

  sdram_cmd_encoder sdram_cmd_encoder_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .init_req    (init_req),
    .access_req  (access_req),
    .sdram_cke   (sdram_cke),
    .sdram_cs_n  (sdram_cs_n),
    .sdram_ras_n (sdram_ras_n),
    .sdram_cas_n (sdram_cas_n),
    .sdram_we_n  (sdram_we_n),
    .sdram_ba    (sdram_ba),
    .sdram_addr  (sdram_addr)
  );

  sdram_data_path sdram_data_path_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_phase     (wr_phase),
    .wr_data      (wr_data),
    .rd_window    (rd_window),
    .sdram_dq_in  (sdram_dq_in),
    .sdram_dq_out (sdram_dq_out),
    .sdram_dq_oe  (sdram_dq_oe),
    .rd_data      (rd_data),
    .rd_ack       (rd_ack)
  );

endmodule

// ==== sim/sdram_model.sv ====
`include "sdram_macros.svh"

module sdram_model (
  input  logic                   clk,
  input  logic                   cke,
  input  logic                   cs_n,
  input  logic                   ras_n,
  input  logic                   cas_n,
  input  logic                   we_n,
  input  logic                   ba,
  input  logic [10:0]            addr,
  input  sdram_pkg::sdram_data_t dq_wr,   // controller drives this
  input  logic                   dq_oe,
  output sdram_pkg::sdram_data_t dq_rd,   // back to the controller
  output logic                   error
);
  import sdram_pkg::*;

  sdram_data_t mem [int];     // sparse, absent words read zero
  int          cyc = 0;
  int          last_act [2] = '{-100, -100};
  int          last_pre [2] = '{-100, -100};
  int          last_ref = -100;
  int          last_mode = -100;
  int          last_wdata = -100;
  logic        row_open [2] = '{1'b0, 1'b0};
  logic [10:0] open_row [2];
  logic        rd_on = 1'b0;  // read burst running in command time
  logic        wr_on = 1'b0;
  logic        cur_ba;
  logic [7:0]  col;
  logic [1:0]  p_valid = '0;  // cl-1 deep return pipe
  sdram_data_t p_data [2];

  initial begin
    error = 1'b0;
    dq_rd = 16'hdead;
  end

  function automatic int key(input logic b, input logic [10:0] r, input logic [7:0] c);
    return int'({b, r, c});
  endfunction

  task automatic flag(input string msg);
    $display("sdram model error at %0t: %s", $time, msg);
    error = 1'b1;
  endtask

  task automatic store_word();
    if (!dq_oe)
      flag("write data arrived while output enable was low");
    mem[key(cur_ba, open_row[cur_ba], col)] = dq_wr;
    col = col + 1'b1;          // full page wraps
    last_wdata = cyc;
  endtask

  always @(posedge clk) begin : sample
    logic        new_v;
    sdram_data_t new_d;
    logic        is_nop;
    new_v  = 1'b0;
    new_d  = '0;
    cyc    = cyc + 1;
    is_nop = !cke || cs_n || ({ras_n, cas_n, we_n} == 3'b111);
    if (is_nop) begin
      if (rd_on) begin
        new_v = 1'b1;
        new_d = mem.exists(key(cur_ba, open_row[cur_ba], col)) ?
                mem[key(cur_ba, open_row[cur_ba], col)] : '0;
        col = col + 1'b1;
      end else if (wr_on) begin
        store_word();
      end else if (dq_oe) begin
        flag("output enable high outside a write burst");
      end
    end else begin
      case ({ras_n, cas_n, we_n})
        3'b011: begin  // active
          if (row_open[ba]) flag("active on a bank that is already open");
          if (cyc - last_pre[ba] < `SDRAM_TRP) flag("precharge to active gap below tRP");
          if (cyc - last_mode < `SDRAM_TMRD) flag("load mode to active gap below tMRD");
          row_open[ba] = 1'b1;
          open_row[ba] = addr;
          last_act[ba] = cyc;
        end
        3'b101, 3'b100: begin  // read or write
          if (!row_open[ba]) flag("column access to a closed bank");
          if (cyc - last_act[ba] < `SDRAM_TRCD) flag("active to column gap below tRCD");
          if (rd_on || p_valid != 2'b00) flag("column access while read data still due");
          cur_ba = ba;
          col    = addr[7:0];
          if (!we_n) begin
            wr_on = 1'b1;
            store_word();
          end else begin
            rd_on = 1'b1;
            new_v = 1'b1;
            new_d = mem.exists(key(cur_ba, open_row[cur_ba], col)) ?
                    mem[key(cur_ba, open_row[cur_ba], col)] : '0;
            col = col + 1'b1;
          end
        end
        3'b110: begin  // burst stop, reads end after cl-1 more words
          rd_on = 1'b0;
          wr_on = 1'b0;
        end
        3'b010: begin  // precharge
          if (rd_on || p_valid != 2'b00) flag("precharge before the last read word returned");
          if (cyc - last_wdata < `SDRAM_TWR) flag("last write word to precharge gap below tWR");
          wr_on = 1'b0;
          if (addr[10]) begin
            row_open = '{1'b0, 1'b0};
            last_pre = '{cyc, cyc};
          end else begin
            row_open[ba] = 1'b0;
            last_pre[ba] = cyc;
          end
        end
        3'b001: begin  // auto refresh
          if (row_open[0] || row_open[1]) flag("auto refresh with a bank open");
          if (cyc - last_pre[0] < `SDRAM_TRP) flag("precharge to refresh gap below tRP");
          if (cyc - last_ref < `SDRAM_TRC) flag("refresh to refresh gap below tRC");
          last_ref = cyc;
        end
        default: begin  // load mode
          if (cyc - last_ref < `SDRAM_TRC) flag("refresh to load mode gap below tRC");
          last_mode = cyc;
        end
      endcase
    end
    // word of a command cycle shows up cl cycles later
    dq_rd      <= p_valid[1] ? p_data[1] : 16'hdead;
    p_valid[1] <= p_valid[0];
    p_data[1]  <= p_data[0];
    p_valid[0] <= new_v;
    p_data[0]  <= new_d;
  end

endmodule

// ==== sim/tb_sdram_ctrl.sv ====
module tb_sdram_ctrl;
  import sdram_pkg::*;

  localparam int clk_period = 40;
  localparam int n_trans    = 24;
  localparam int max_cycles = 200 + 100 + n_trans * 300;  // init + margin + worst bursts

  logic        clk, rst_n;
  logic        wr_req, wr_ack, rd_req, rd_ack, init_done;
  sys_addr_t   wr_addr, rd_addr;
  burst_t      wr_burst, rd_burst;
  sdram_data_t wr_data, rd_data, dq_in, dq_out;
  logic        cke, cs_n, ras_n, cas_n, we_n, ba, dq_oe, model_err;
  logic [10:0] pin_addr;

  sdram_data_t ref_mem [int];   // expected contents, absent means zero
  sys_addr_t   written [$];
  sys_addr_t   exp_addr;        // address of the access in flight
  int          cycles = 0;
  time         first_wr_t, first_rd_t;

  sdram_ctrl_top #(.init_wait_cycles(200)) sdram_ctrl_top_inst (
    .clk (clk), .rst_n (rst_n),
    .wr_req (wr_req), .wr_ack (wr_ack), .wr_addr (wr_addr),
    .wr_burst (wr_burst), .wr_data (wr_data),
    .rd_req (rd_req), .rd_ack (rd_ack), .rd_addr (rd_addr),
    .rd_burst (rd_burst), .rd_data (rd_data), .init_done (init_done),
    .sdram_cke (cke), .sdram_cs_n (cs_n), .sdram_ras_n (ras_n),
    .sdram_cas_n (cas_n), .sdram_we_n (we_n), .sdram_ba (ba),
    .sdram_addr (pin_addr), .sdram_dq_in (dq_in), .sdram_dq_out (dq_out),
    .sdram_dq_oe (dq_oe)
  );

  sdram_model sdram_model_inst (
    .clk (clk), .cke (cke), .cs_n (cs_n), .ras_n (ras_n), .cas_n (cas_n),
    .we_n (we_n), .ba (ba), .addr (pin_addr), .dq_wr (dq_out), .dq_oe (dq_oe),
    .dq_rd (dq_in), .error (model_err)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input sdram_data_t exp, input sdram_data_t act, input string what);
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, act);
      fail_run("data check failed");
    end
  endtask

  task automatic check_count(input burst_t exp, input burst_t act, input string what);
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, act);
      fail_run("count check failed");
    end
  endtask

  task automatic check_addr(input sys_addr_t exp, input sys_addr_t act, input string what);
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, act);
      fail_run("address check failed");
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycles)
      fail_run($sformatf("timeout: run did not finish within %0d cycles", max_cycles));
  end

  always @(negedge clk) begin
    if (model_err)
      fail_run("the sdram model saw a protocol or timing violation");
  end

  // pin levels to command, per the sdram truth table
  function automatic sdram_cmd_e pin_cmd();
    if (!cke) return cmd_inhibit;
    if (cs_n) return cmd_nop;
    case ({ras_n, cas_n, we_n})
      3'b011:  return cmd_active;
      3'b101:  return cmd_read;
      3'b100:  return cmd_write;
      3'b110:  return cmd_burst_stop;
      3'b010:  return cmd_precharge;
      3'b001:  return cmd_auto_refresh;
      3'b000:  return cmd_load_mode;
      default: return cmd_nop;
    endcase
  endfunction

  // bank and row on active, bank and column on read or write
  always @(negedge clk) begin
    if (pin_cmd() == cmd_active)
      check_addr({exp_addr[19:8], 8'd0}, {ba, pin_addr, 8'd0}, "active bank and row");
    else if (pin_cmd() == cmd_read || pin_cmd() == cmd_write)
      check_addr({exp_addr[19], 3'b000, exp_addr[7:0], 8'd0}, {ba, pin_addr, 8'd0},
                 "column command bank and column");   // a10 low, no auto precharge
  end

  function automatic sdram_data_t ref_word(input sys_addr_t a);
    return ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : '0;
  endfunction

  function automatic burst_t rand_burst(input sys_addr_t a);
    return burst_t'(1 + $urandom % (256 - int'(a[7:0])));  // stays in the page
  endfunction

  task automatic check_init();
    sdram_cmd_e  seen [$];
    logic [10:0] seen_addr [$];
    sdram_cmd_e  c;
    wr_req = 1'b1;   // both pending, must wait for init
    rd_req = 1'b1;
    while (!init_done) begin
      @(negedge clk);
      if (wr_ack || rd_ack)
        fail_run("an acknowledge went high before initialization finished");
      c = pin_cmd();
      if (c != cmd_nop && c != cmd_inhibit) begin
        seen.push_back(c);
        seen_addr.push_back(pin_addr);
      end
    end
    wr_req = 1'b0;   // dropped before idle can accept
    rd_req = 1'b0;
    check_count(burst_t'(10), burst_t'(seen.size()), "init command count");
    if (seen[0] != cmd_precharge || !seen_addr[0][10])
      fail_run("init did not start with a precharge of all banks");
    for (int i = 1; i <= 8; i++)
      if (seen[i] != cmd_auto_refresh)
        fail_run("init refresh sequence is wrong");
    if (seen[9] != cmd_load_mode)
      fail_run("init did not end with load mode");
    // cl 3, sequential, full page
    check_word(sdram_data_t'({4'b0000, 3'd3, 1'b0, 3'd7}), sdram_data_t'(seen_addr[9]),
               "mode register word");
  endtask

  task automatic do_write(input sys_addr_t a, input burst_t n);
    sdram_data_t words [$];
    int          acks;
    acks = 0;
    for (int i = 0; i < int'(n); i++)
      words.push_back(sdram_data_t'($urandom));
    @(negedge clk);
    wr_addr  = a;
    wr_burst = n;
    wr_data  = words[0];
    wr_req   = 1'b1;
    exp_addr = a;
    forever begin
      @(negedge clk);
      if (acks < int'(n)) wr_data = words[acks];  // word for this cycle
      if (wr_ack) begin
        if (acks == 0) first_wr_t = $time;
        wr_req = 1'b0;
        if (acks < int'(n)) ref_mem[int'(a) + acks] = words[acks];
        acks++;
      end else if (acks > 0) begin
        break;
      end
    end
    check_count(n, burst_t'(acks), "write ack cycles");
    written.push_back(a);
  endtask

  task automatic do_read(input sys_addr_t a, input burst_t n);
    int acks;
    acks = 0;
    @(negedge clk);
    rd_addr  = a;
    rd_burst = n;
    rd_req   = 1'b1;
    exp_addr = a;
    forever begin
      @(negedge clk);
      if (rd_ack) begin
        if (acks == 0) first_rd_t = $time;
        rd_req = 1'b0;
        check_word(ref_word(a + sys_addr_t'(acks)), rd_data, "read word");
        acks++;
      end else if (acks > 0) begin
        break;
      end
    end
    check_count(n, burst_t'(acks), "read ack cycles");
  endtask

  initial begin
    sys_addr_t a;
    void'($urandom(71765));
    rst_n    = 1'b0;
    wr_req   = 1'b0;
    rd_req   = 1'b0;
    wr_addr  = '0;
    rd_addr  = '0;
    wr_burst = '0;
    rd_burst = '0;
    wr_data  = '0;
    exp_addr = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_init();

    // one burst written then read back
    a = {1'b1, 11'd37, 8'd20};
    do_write(a, burst_t'(6));
    do_read(a, burst_t'(6));

    // both requests in the same idle cycle
    a = {1'b0, 11'd1500, 8'd100};
    fork
      do_write(a, burst_t'(4));
      do_read(a, burst_t'(4));
    join
    if (first_wr_t >= first_rd_t)
      fail_run("read was acknowledged before the simultaneous write");

    for (int t = 0; t < n_trans; t++) begin
      if ($urandom % 2 == 0) begin
        a = sys_addr_t'($urandom);
        do_write(a, rand_burst(a));
      end else begin
        if ($urandom % 4 == 0)
          a = sys_addr_t'($urandom);   // mostly unwritten, reads zero
        else
          a = written[$urandom % written.size()];
        do_read(a, rand_burst(a));
      end
    end

    repeat (10) @(negedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
design/sdram_pkg.sv
design/sdram_init_seq.sv
design/sdram_access_fsm.sv
design/sdram_cmd_encoder.sv
design/sdram_data_path.sv
design/sdram_ctrl_top.sv
sim/sdram_model.sv
sim/tb_sdram_ctrl.sv

// ==== Makefile ====
# Verilator simulation of the SDRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_sdram_ctrl
SEED      ?= 71765
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f sources.f --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
